/* include/tpu_settings.svh */
/*
 * Build-time settings of the reduced TPU
 * Lane count, data word width, instruction memory depth
 * and width of the issue number
 */
`ifndef TPU_SETTINGS_SVH
`define TPU_SETTINGS_SVH

// Number of vector lanes built in the top-level generate loop
`define TPU_NUM_LANES	4

`define TPU_DATA_W		16		// Lane data word
`define TPU_IMEM_DEPTH	16		// Instruction memory entries
`define TPU_ISSUE_NO_W	4		// Issue number from the master

`endif

/* src/pkg_tpu.sv */
/*
 * Shared types of the reduced TPU
 * Opcode and front-end state enums, instruction field widths
 */
package pkg_tpu;

	////////////////////////////////////////
	// Opcodes
	typedef enum logic [2:0] {
		OP_NOP	= 3'd0,		// No operation
		OP_LDI	= 3'd1,		// rd = imm + lane index
		OP_ADD	= 3'd2,		// rd = ra + rb
		OP_MUL	= 3'd3,		// rd = ra * rb, low half
		OP_SUM	= 3'd4,		// Return rd to reduction
		OP_END	= 3'd5		// Close program
	} opcode_t;

	////////////////////////////////////////
	// Front-end states
	typedef enum logic [1:0] {
		FE_LOAD	= 2'd0,		// Filling instruction memory
		FE_RUN	= 2'd1,		// Program executing
		FE_DONE	= 2'd2		// Termination seen
	} fe_state_t;

	// Field widths, opcode|rd|ra|rb|imm from the MSB down
	localparam int REG_SEL_W	= 2;
	localparam int IMM_W		= 8;
	localparam int INSTR_W		= $bits(opcode_t) + 3 * REG_SEL_W + IMM_W;

endpackage

/* src/tpu_front_end.sv */
/*
 * Front end of the reduced TPU
 * Request accept/nack decision, instruction memory with registered read,
 * write pointer, program length, issue number latch and start strobe
 */
`timescale 1ns/1ps
`include "tpu_settings.svh"

module tpu_front_end (
	input	logic							clock,
	input	logic							arst_n,
	input	logic							en_exe,			// Execution allowed
	input	logic							req,			// Request strobe
	input	logic [`TPU_ISSUE_NO_W-1:0]		issue_no,
	input	logic [pkg_tpu::INSTR_W-1:0]	instr,
	input	logic							imem_re,		// Fetch from scalar unit
	input	logic [$clog2(`TPU_IMEM_DEPTH)-1:0]	imem_addr,
	input	logic							run_done,		// END drained by reduction
	output	logic [pkg_tpu::INSTR_W-1:0]	imem_data,
	output	logic [$clog2(`TPU_IMEM_DEPTH):0]	prog_len,
	output	logic							start,
	output	logic							nack,
	output	logic [`TPU_ISSUE_NO_W-1:0]		term_issue_no
);

	localparam int DEPTH	= `TPU_IMEM_DEPTH;
	localparam int PTR_W	= $clog2(DEPTH);
	localparam int LEN_W	= PTR_W + 1;

	logic [pkg_tpu::INSTR_W-1:0]	imem [DEPTH];
	logic [LEN_W-1:0]				wr_ptr;
	pkg_tpu::fe_state_t				state;
	pkg_tpu::opcode_t				req_op;
	logic							started;		// Start already given
	logic							accept;

	assign req_op	= pkg_tpu::opcode_t'(instr[pkg_tpu::INSTR_W-1 -: $bits(pkg_tpu::opcode_t)]);
	assign accept	= req && (state == pkg_tpu::FE_LOAD) && (wr_ptr < LEN_W'(DEPTH));

	////////////////////////////////////////
	// Control FSM
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state			<= pkg_tpu::FE_LOAD;
			wr_ptr			<= '0;
			prog_len		<= '0;
			started			<= 1'b0;
			start			<= 1'b0;
			nack			<= 1'b0;
			term_issue_no	<= '0;
		end else begin
			nack	<= req && !accept;		// Busy or memory full
			start	<= 1'b0;
			case (state)
				pkg_tpu::FE_LOAD: begin
					if (accept) begin
						wr_ptr <= wr_ptr + 1'b1;
						if (wr_ptr == '0)
							term_issue_no <= issue_no;		// First word of program
						if (req_op == pkg_tpu::OP_END) begin
							state		<= pkg_tpu::FE_RUN;
							prog_len	<= wr_ptr + 1'b1;
						end
					end
				end
				pkg_tpu::FE_RUN: begin
					if (en_exe && !started) begin
						start	<= 1'b1;
						started	<= 1'b1;
					end
					if (run_done)
						state <= pkg_tpu::FE_DONE;
				end
				default: begin
					state	<= pkg_tpu::FE_LOAD;
					wr_ptr	<= '0;
					started	<= 1'b0;
				end
			endcase
		end
	end

	// Instruction storage, read data one cycle after imem_re
	always_ff @(posedge clock) begin
		if (accept)
			imem[wr_ptr[PTR_W-1:0]] <= instr;
		if (imem_re)
			imem_data <= imem[imem_addr];
	end

	// Full memory takes no write, the pointer only moves on the clear
	a_no_write_when_full: assert property (@(posedge clock) disable iff (!arst_n)
		(wr_ptr == LEN_W'(DEPTH)) |=> ((wr_ptr == LEN_W'(DEPTH)) || (wr_ptr == '0)));
	a_start_in_run: assert property (@(posedge clock) disable iff (!arst_n)
		start |-> (state == pkg_tpu::FE_RUN));

endmodule

/* src/tpu_scalar_unit.sv */
/*
 * Scalar unit of the reduced TPU
 * Program counter, one fetch per cycle from the instruction memory,
 * and the registered vector command broadcast to the lanes
 */
`timescale 1ns/1ps
`include "tpu_settings.svh"

module tpu_scalar_unit (
	input	logic							clock,
	input	logic							arst_n,
	input	logic							start,			// Program ready to run
	input	logic [$clog2(`TPU_IMEM_DEPTH):0]	prog_len,
	input	logic [pkg_tpu::INSTR_W-1:0]	imem_data,
	output	logic							imem_re,
	output	logic [$clog2(`TPU_IMEM_DEPTH)-1:0]	imem_addr,
	output	logic							cmd_valid,		// Command strobe to lanes
	output	logic [pkg_tpu::INSTR_W-1:0]	cmd_instr
);

	localparam int PTR_W	= $clog2(`TPU_IMEM_DEPTH);
	localparam int LEN_W	= PTR_W + 1;

	logic [LEN_W-1:0]	pc;
	logic				busy;			// Fetches after the first
	logic				fetch_vld;		// imem_data holds a word

	// Word 0 is fetched in the start cycle itself
	assign imem_re		= start | busy;
	assign imem_addr	= start ? '0 : pc[PTR_W-1:0];

	////////////////////////////////////////
	// Fetch sequencer
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pc			<= '0;
			busy		<= 1'b0;
			fetch_vld	<= 1'b0;
			cmd_valid	<= 1'b0;
		end else begin
			fetch_vld	<= imem_re;
			cmd_valid	<= fetch_vld;
			if (start) begin
				pc		<= LEN_W'(1);
				busy	<= (prog_len > LEN_W'(1));
			end else if (busy) begin
				pc <= pc + 1'b1;
				if (pc == prog_len - 1'b1)
					busy <= 1'b0;		// Last word fetched
			end
		end
	end

	// Broadcast register
	always_ff @(posedge clock) begin
		if (fetch_vld)
			cmd_instr <= imem_data;
	end

	a_no_start_while_busy: assert property (@(posedge clock) disable iff (!arst_n)
		start |-> !busy);

endmodule

/* src/tpu_vector_lane.sv */
/*
 * One vector lane of the reduced TPU
 * Four-entry register file, LDI/ADD/MUL execution,
 * registered return of a register on SUM and of zero on END
 */
`timescale 1ns/1ps
`include "tpu_settings.svh"

module tpu_vector_lane #(
	parameter int LANE_ID = 0
) (
	input	logic							clock,
	input	logic							arst_n,
	input	logic							cmd_valid,
	input	logic [pkg_tpu::INSTR_W-1:0]	cmd_instr,
	output	logic							lane_valid,		// Return to reduction
	output	logic [`TPU_DATA_W-1:0]			lane_data
);

	localparam int DATA_W = `TPU_DATA_W;

	logic [DATA_W-1:0]				regs [2**pkg_tpu::REG_SEL_W];
	logic [$bits(pkg_tpu::opcode_t)-1:0]	op_bits;
	pkg_tpu::opcode_t				op;
	logic [pkg_tpu::REG_SEL_W-1:0]	rd;
	logic [pkg_tpu::REG_SEL_W-1:0]	ra;
	logic [pkg_tpu::REG_SEL_W-1:0]	rb;
	logic [pkg_tpu::IMM_W-1:0]		imm;

	assign {op_bits, rd, ra, rb, imm} = cmd_instr;
	assign op = pkg_tpu::opcode_t'(op_bits);

	// Writes land at the next edge, visible to the following command
	always_ff @(posedge clock) begin
		if (cmd_valid) begin
			case (op)
				pkg_tpu::OP_LDI: regs[rd] <= DATA_W'(imm) + DATA_W'(LANE_ID);
				pkg_tpu::OP_ADD: regs[rd] <= regs[ra] + regs[rb];
				pkg_tpu::OP_MUL: regs[rd] <= regs[ra] * regs[rb];		// Low half kept
				default: ;
			endcase
			lane_data <= (op == pkg_tpu::OP_END) ? '0 : regs[rd];
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			lane_valid <= 1'b0;
		else
			lane_valid <= cmd_valid && (op == pkg_tpu::OP_SUM || op == pkg_tpu::OP_END);
	end

endmodule

/* src/tpu_lane_reduce.sv */
/*
 * Reduction unit of the reduced TPU
 * Sums the lane returns into one scalar result,
 * tells SUM from END through a two-entry kind record
 */
`timescale 1ns/1ps
`include "tpu_settings.svh"

module tpu_lane_reduce (
	input	logic							clock,
	input	logic							arst_n,
	input	logic [pkg_tpu::INSTR_W-1:0]	cmd_instr,
	input	logic [`TPU_NUM_LANES-1:0]		lane_valid,
	input	logic [`TPU_NUM_LANES-1:0][`TPU_DATA_W-1:0]	lane_data,
	output	logic							result_valid,
	output	logic [`TPU_DATA_W-1:0]			result,
	output	logic							term,
	output	logic							run_done		// Back to front end
);

	localparam int NUM_LANES	= `TPU_NUM_LANES;
	localparam int DATA_W		= `TPU_DATA_W;

	pkg_tpu::opcode_t	cmd_op;
	logic [1:0]			end_hist;		// [0] lane stage, [1] output stage
	logic				out_vld;
	logic [DATA_W-1:0]	lane_sum;

	assign cmd_op = pkg_tpu::opcode_t'(cmd_instr[pkg_tpu::INSTR_W-1 -: $bits(pkg_tpu::opcode_t)]);

	always_comb begin
		lane_sum = '0;
		for (int i = 0; i < NUM_LANES; i++)
			lane_sum = lane_sum + lane_data[i];		// Wraps modulo 2^16
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			end_hist	<= 2'b00;
			out_vld		<= 1'b0;
		end else begin
			end_hist	<= {end_hist[0], cmd_op == pkg_tpu::OP_END};
			out_vld		<= lane_valid[0];
		end
	end

	always_ff @(posedge clock) begin
		if (lane_valid[0])
			result <= lane_sum;
	end

	assign result_valid	= out_vld & ~end_hist[1];
	assign term			= out_vld & end_hist[1];
	assign run_done		= term;

	a_lanes_in_step: assert property (@(posedge clock) disable iff (!arst_n)
		(lane_valid == '0) || (&lane_valid));

endmodule

/* src/tpu_top.sv */
/*
 * Top level of the reduced TPU
 * Front end, scalar unit, vector lane array and reduction unit
 */
`timescale 1ns/1ps
`include "tpu_settings.svh"

module tpu_top (
	input	logic							clock,
	input	logic							arst_n,
	input	logic							en_exe,			// Enable executing
	input	logic							req,			// Request from master
	input	logic [`TPU_ISSUE_NO_W-1:0]		issue_no,
	input	logic [pkg_tpu::INSTR_W-1:0]	instr,
	output	logic							nack,			// Request refused
	output	logic							result_valid,
	output	logic [`TPU_DATA_W-1:0]			result,
	output	logic							term,			// Program terminated
	output	logic [`TPU_ISSUE_NO_W-1:0]		term_issue_no
);

	logic									start;
	logic [$clog2(`TPU_IMEM_DEPTH):0]		prog_len;
	logic									imem_re;
	logic [$clog2(`TPU_IMEM_DEPTH)-1:0]		imem_addr;
	logic [pkg_tpu::INSTR_W-1:0]			imem_data;
	logic									cmd_valid;
	logic [pkg_tpu::INSTR_W-1:0]			cmd_instr;
	logic [`TPU_NUM_LANES-1:0]				lane_valid;
	logic [`TPU_NUM_LANES-1:0][`TPU_DATA_W-1:0]	lane_data;
	logic									run_done;

	////////////////////////////////////////
	// Request handling and instruction memory
	tpu_front_end u_front_end (
		.clock(clock),				.arst_n(arst_n),
		.en_exe(en_exe),			.req(req),
		.issue_no(issue_no),		.instr(instr),
		.imem_re(imem_re),			.imem_addr(imem_addr),
		.run_done(run_done),		.imem_data(imem_data),
		.prog_len(prog_len),		.start(start),
		.nack(nack),				.term_issue_no(term_issue_no)
	);

	tpu_scalar_unit u_scalar_unit (
		.clock(clock),				.arst_n(arst_n),
		.start(start),				.prog_len(prog_len),
		.imem_data(imem_data),		.imem_re(imem_re),
		.imem_addr(imem_addr),		.cmd_valid(cmd_valid),
		.cmd_instr(cmd_instr)
	);

	////////////////////////////////////////
	// Lane array
	for (genvar i = 0; i < `TPU_NUM_LANES; i++) begin : g_lane
		tpu_vector_lane #(.LANE_ID(i)) u_lane (
			.clock(clock),				.arst_n(arst_n),
			.cmd_valid(cmd_valid),		.cmd_instr(cmd_instr),
			.lane_valid(lane_valid[i]),	.lane_data(lane_data[i])
		);
	end

	tpu_lane_reduce u_lane_reduce (
		.clock(clock),				.arst_n(arst_n),
		.cmd_instr(cmd_instr),		.lane_valid(lane_valid),
		.lane_data(lane_data),		.result_valid(result_valid),
		.result(result),			.term(term),
		.run_done(run_done)
	);

endmodule

/* tb/tpu_checker.sv */
/*
 * Response checker of the TPU testbench
 * Expected result, term and nack records pushed by the stimulus driver,
 * comparison of every output strobe against them, error counting
 */
`timescale 1ns/1ps
`include "tpu_settings.svh"

module tpu_checker (
	input	logic						clock,
	input	logic						arst_n,
	input	logic						exp_push,		// One expectation per strobe
	input	logic [1:0]					exp_kind,		// 0 result, 1 term, 2 nack
	input	logic [`TPU_DATA_W-1:0]		exp_value,
	input	logic						drain_check,	// End of run, nothing may be left
	input	logic						req,
	input	logic						nack,
	input	logic						result_valid,
	input	logic [`TPU_DATA_W-1:0]		result,
	input	logic						term,
	input	logic [`TPU_ISSUE_NO_W-1:0]	term_issue_no,
	output	int							error_count,
	output	int							pending			// Expectations not yet seen
);

	logic [`TPU_DATA_W-1:0]		exp_results [$];
	logic [`TPU_ISSUE_NO_W-1:0]	exp_terms [$];
	int							exp_nacks;
	logic [`TPU_DATA_W-1:0]		exp_result;
	logic [`TPU_ISSUE_NO_W-1:0]	exp_term;
	logic						req_seen;		// req in the previous cycle

	initial begin
		error_count	= 0;
		pending		= 0;
		exp_nacks	= 0;
		req_seen	= 1'b0;
	end

	////////////////////////////////////////
	// Compare at the falling edge, outputs are settled there
	always @(negedge clock) begin
		if (arst_n) begin
			if (exp_push) begin
				case (exp_kind)
					2'd0: exp_results.push_back(exp_value);
					2'd1: exp_terms.push_back(exp_value[`TPU_ISSUE_NO_W-1:0]);
					default: exp_nacks++;
				endcase
			end
			if (nack) begin
				if (!req_seen) begin
					$display("Nack at %0t without a request one cycle before", $time);
					error_count++;
				end else if (exp_nacks == 0) begin
					$display("Unexpected nack at %0t, a word that should fit was refused", $time);
					error_count++;
				end else
					exp_nacks--;
			end
			if (result_valid) begin
				if (exp_results.size() == 0) begin
					$display("Unexpected result strobe at %0t", $time);
					error_count++;
				end else begin
					exp_result = exp_results.pop_front();
					if (result !== exp_result) begin
						$display("[ERROR] result: got 0x%h, expected 0x%h", result, exp_result);
						error_count++;
					end
				end
			end
			if (term) begin
				if (exp_results.size() != 0) begin
					$display("Term at %0t came before %0d expected results",
						$time, exp_results.size());
					error_count++;
					exp_results.delete();
				end
				if (exp_terms.size() == 0) begin
					$display("Unexpected term strobe at %0t", $time);
					error_count++;
				end else begin
					exp_term = exp_terms.pop_front();
					if (term_issue_no !== exp_term) begin
						$display("[ERROR] term_issue_no: got 0x%h, expected 0x%h",
							term_issue_no, exp_term);
						error_count++;
					end
				end
			end
			if (drain_check && (exp_results.size() + exp_terms.size() + exp_nacks) != 0) begin
				$display("Never seen at end of run: %0d results, %0d terms, %0d nacks",
					exp_results.size(), exp_terms.size(), exp_nacks);
				error_count++;
			end
			req_seen	= req;
			pending		= exp_results.size() + exp_terms.size() + exp_nacks;
		end
	end

endmodule

/* tb/tb_tpu.sv */
/*
 * Testbench top of the reduced TPU
 * Clock and reset, golden file reader, request driver with random gaps,
 * UUT and response checker instances, closing report
 */
`timescale 1ns/1ps
`include "tpu_settings.svh"

module tb_tpu;

	localparam int TERM_TIMEOUT		= 200;		// Cycles from last request to term
	localparam int DRAIN_TIMEOUT	= 50;
	localparam int QUIET_CYCLES		= 20;		// Watch for stray strobes at the end

	logic							clock;
	logic							arst_n;
	logic							en_exe;
	logic							req;
	logic [`TPU_ISSUE_NO_W-1:0]		issue_no;
	logic [pkg_tpu::INSTR_W-1:0]	instr;
	logic							nack;
	logic							result_valid;
	logic [`TPU_DATA_W-1:0]			result;
	logic							term;
	logic [`TPU_ISSUE_NO_W-1:0]		term_issue_no;
	logic							exp_push;
	logic [1:0]						exp_kind;
	logic [`TPU_DATA_W-1:0]			exp_value;
	logic							drain_check;
	int								error_count;
	int								pending;
	int								run_errors;
	int								terms_seen;		// Term strobes so far
	int								terms_awaited;
	int								fd;
	int								code;
	logic [63:0]					tag;
	logic [8*120-1:0]				line;
	logic [31:0]					f_issue, f_op, f_rd, f_ra, f_rb, f_imm, f_val;
	logic [pkg_tpu::INSTR_W-1:0]	send_instr [$];		// Words of the current block
	logic [`TPU_ISSUE_NO_W-1:0]		send_issue [$];
	logic [1:0]						push_kind [$];		// Expectations of the current block
	logic [`TPU_DATA_W-1:0]			push_val [$];

	tpu_top UUT (
		.clock(clock),					.arst_n(arst_n),
		.en_exe(en_exe),				.req(req),
		.issue_no(issue_no),			.instr(instr),
		.nack(nack),					.result_valid(result_valid),
		.result(result),				.term(term),
		.term_issue_no(term_issue_no)
	);

	tpu_checker u_checker (
		.clock(clock),					.arst_n(arst_n),
		.exp_push(exp_push),			.exp_kind(exp_kind),
		.exp_value(exp_value),			.drain_check(drain_check),
		.req(req),						.nack(nack),
		.result_valid(result_valid),	.result(result),
		.term(term),					.term_issue_no(term_issue_no),
		.error_count(error_count),		.pending(pending)
	);

	always #4 clock = ~clock;

	// Term strobes, counted where outputs are settled
	always @(negedge clock) begin
		if (arst_n && term)
			terms_seen++;
	end

	////////////////////////////////////////
	// Request driver
	task automatic send_word(input logic [`TPU_ISSUE_NO_W-1:0] num,
			input logic [pkg_tpu::INSTR_W-1:0] word);
		int gap;
		gap = $urandom % 4;		// Idle cycles before the request
		repeat (gap) @(posedge clock);
		@(posedge clock);
		req			<= 1'b1;
		issue_no	<= num;
		instr		<= word;
		@(posedge clock);
		req			<= 1'b0;
	endtask

	task automatic wait_for_term();
		int cycles;
		cycles = 0;
		terms_awaited++;
		while (terms_seen < terms_awaited && cycles < TERM_TIMEOUT) begin
			@(posedge clock);
			cycles++;
		end
		if (terms_seen < terms_awaited) begin
			$display("Timeout: no term within %0d cycles of the last request", TERM_TIMEOUT);
			run_errors++;
			terms_awaited = terms_seen;
		end
	endtask

	// Hand the expectations to the checker first, then send the words
	task automatic run_block(input bit has_term);
		while (push_kind.size() != 0) begin
			@(posedge clock);
			exp_push	<= 1'b1;
			exp_kind	<= push_kind.pop_front();
			exp_value	<= push_val.pop_front();
		end
		@(posedge clock);
		exp_push <= 1'b0;
		while (send_instr.size() != 0)
			send_word(send_issue.pop_front(), send_instr.pop_front());
		if (has_term)
			wait_for_term();
	endtask

	task automatic wait_for_drain();
		int cycles;
		cycles = 0;
		while (pending != 0 && cycles < DRAIN_TIMEOUT) begin
			@(posedge clock);
			cycles++;
		end
		if (pending != 0) begin
			$display("Timeout: %0d expected strobes still outstanding", pending);
			run_errors++;
		end
		repeat (QUIET_CYCLES) @(posedge clock);
		drain_check <= 1'b1;
		@(posedge clock);
		drain_check <= 1'b0;
		@(posedge clock);
	endtask

	////////////////////////////////////////
	// Main sequence
	initial begin
		void'($urandom(26));
		clock			= 1'b0;
		arst_n			= 1'b0;
		en_exe			= 1'b0;
		req				= 1'b0;
		issue_no		= '0;
		instr			= '0;
		exp_push		= 1'b0;
		exp_kind		= 2'd0;
		exp_value		= '0;
		drain_check		= 1'b0;
		run_errors		= 0;
		terms_seen		= 0;
		terms_awaited	= 0;
		repeat (10) @(posedge clock);
		arst_n	<= 1'b1;
		en_exe	<= 1'b1;

		fd = $fopen("tb/tpu_golden.txt", "r");
		if (fd == 0) begin
			$display("Golden file tb/tpu_golden.txt could not be opened");
			run_errors++;
		end
		code = (fd != 0) ? $fscanf(fd, "%s", tag) : 0;
		while (code == 1) begin
			case (tag)
				"#": code = $fgets(line, fd);
				"P", "X": begin
					code = $fscanf(fd, "%h %h %h %h %h %h",
						f_issue, f_op, f_rd, f_ra, f_rb, f_imm);
					send_issue.push_back(f_issue[`TPU_ISSUE_NO_W-1:0]);
					send_instr.push_back({f_op[2:0], f_rd[1:0], f_ra[1:0],
						f_rb[1:0], f_imm[7:0]});
					if (tag == "X") begin
						push_kind.push_back(2'd2);
						push_val.push_back('0);
					end
				end
				"R": begin
					code = $fscanf(fd, "%h", f_val);
					push_kind.push_back(2'd0);
					push_val.push_back(f_val[`TPU_DATA_W-1:0]);
				end
				"T": begin
					code = $fscanf(fd, "%h", f_val);
					push_kind.push_back(2'd1);
					push_val.push_back(f_val[`TPU_DATA_W-1:0]);
					run_block(1'b1);
				end
				default: begin
					$display("Golden file holds an unknown record type");
					run_errors++;
				end
			endcase
			code = $fscanf(fd, "%s", tag);
		end
		if (fd != 0)
			$fclose(fd);
		run_block(1'b0);		// Words after the last T, no term expected
		wait_for_drain();

		$display("Closing report: %0d check errors, %0d run errors", error_count, run_errors);
		if (error_count == 0 && run_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* tb/tpu_golden.txt */
# P/X issue opcode rd ra rb imm in hex: P is accepted, X must be nacked
# R value is an expected SUM result, T issue closes a program with its term issue number
P 3 1 0 0 0 10
P 3 1 1 0 0 05
P 3 4 0 0 0 00
P 3 4 1 0 0 00
P 3 5 0 0 0 00
X 6 1 0 0 0 ff
X 6 5 0 0 0 00
R 46
R 1a
T 3
P 7 1 0 0 0 03
P 7 1 1 0 0 02
P 7 2 2 0 1 00
P 7 3 3 2 0 00
P 7 2 3 3 2 00
P 7 4 3 0 0 00
P 7 3 2 3 3 00
P 7 3 2 2 2 00
P 7 4 2 0 0 00
P 7 5 0 0 0 00
X 1 2 0 1 1 00
X 1 1 3 0 0 77
R ba
R 7a72
T 7
P a 1 3 0 0 80
P 5 4 3 0 0 00
P 5 5 0 0 0 00
R 206
T a
P 9 1 0 0 0 01
P 9 1 1 0 0 02
P 9 2 2 0 1 00
P 9 0 0 0 0 00
P 9 3 3 2 2 00
P 9 4 3 0 0 00
P 9 0 0 0 0 00
P 9 1 2 0 0 0f
P 9 2 1 1 2 00
P 9 0 0 0 0 00
P 9 4 1 0 0 00
P 9 1 0 0 0 33
P 9 3 0 0 1 00
P 9 0 0 0 0 00
P 9 4 0 0 0 00
P 9 1 3 0 0 44
X 9 5 0 0 0 00

/* build.f */
+incdir+include
src/pkg_tpu.sv
src/tpu_front_end.sv
src/tpu_scalar_unit.sv
src/tpu_vector_lane.sv
src/tpu_lane_reduce.sv
src/tpu_top.sv
tb/tpu_checker.sv
tb/tb_tpu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the TPU testbench with Verilator, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_tpu -f build.f -o sim_tpu \
	> build.log 2>&1 \
	&& ./obj_dir/sim_tpu > sim.log 2>&1 \
	|| { echo "Build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Verification failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
